// File: bench/mem_bridge_asserts.sv
`timescale 1ns/1ns

module mem_bridge_asserts import bridge_pkg::*; (
  input logic              aclk,
  input logic              i_rst_n,
  input logic              i_arvalid,
  input logic              i_arready,
  input logic [ID_W-1:0]   i_arid,
  input logic [ADDR_W-1:0] i_araddr,
  input logic [LEN_W-1:0]  i_arlen,
  input logic              i_awvalid,
  input logic              i_awready,
  input logic [ADDR_W-1:0] i_awaddr,
  input logic              i_wvalid,
  input logic              i_wready,
  input logic [DATA_W-1:0] i_wdata,
  input logic [STRB_W-1:0] i_wstrb,
  input logic              i_iret_valid,
  input logic              i_dret_valid
);

  int fail_count = 0;

  a_ar_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
    i_arvalid && !i_arready |=> i_arvalid && $stable({i_arid, i_araddr, i_arlen}))
    else begin
      $error("arvalid or its payload changed before arready");
      fail_count++;
    end

  a_aw_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
    i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
    else begin
      $error("awvalid or awaddr changed before awready");
      fail_count++;
    end

  a_w_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
    i_wvalid && !i_wready |=> i_wvalid && $stable({i_wdata, i_wstrb}))
    else begin
      $error("wvalid or its payload changed before wready");
      fail_count++;
    end

  // one AXI beat feeds at most one return port
  a_ret_excl: assert property (@(posedge aclk) disable iff (!i_rst_n)
    !(i_iret_valid && i_dret_valid))
    else begin
      $error("both return ports valid in the same cycle");
      fail_count++;
    end

endmodule

bind mem_bridge_top mem_bridge_asserts u_asserts (
  .aclk        (aclk),
  .i_rst_n     (i_rst_n),
  .i_arvalid   (o_arvalid),
  .i_arready   (i_arready),
  .i_arid      (o_arid),
  .i_araddr    (o_araddr),
  .i_arlen     (o_arlen),
  .i_awvalid   (o_awvalid),
  .i_awready   (i_awready),
  .i_awaddr    (o_awaddr),
  .i_wvalid    (o_wvalid),
  .i_wready    (i_wready),
  .i_wdata     (o_wdata),
  .i_wstrb     (o_wstrb),
  .i_iret_valid(o_iret_valid),
  .i_dret_valid(o_dret_valid)
);

// File: bench/tb_mem_bridge.sv
`timescale 1ns/1ns

module tb_mem_bridge import bridge_pkg::*; ();

  localparam int          LINE_BEATS = 4;
  localparam int          TIMEOUT    = 200;
  localparam logic [31:0] FILL       = 32'h5a5a_0000;

  logic              aclk;
  logic              i_rst_n;
  logic              i_ird_req, i_ird_line, o_ird_rdy;
  logic [ADDR_W-1:0] i_ird_addr;
  logic              i_drd_req, i_drd_line, o_drd_rdy;
  logic [ADDR_W-1:0] i_drd_addr;
  logic              i_dwr_req, o_dwr_rdy;
  logic [ADDR_W-1:0] i_dwr_addr;
  logic [STRB_W-1:0] i_dwr_strb;
  logic [DATA_W-1:0] i_dwr_data;
  logic              o_iret_valid, o_iret_last, o_dret_valid, o_dret_last;
  logic [DATA_W-1:0] o_iret_data, o_dret_data;
  logic [ID_W-1:0]   o_arid, i_rid, o_awid, i_bid;
  logic [ADDR_W-1:0] o_araddr, o_awaddr;
  logic [LEN_W-1:0]  o_arlen;
  logic              o_arvalid, i_arready, i_rlast, i_rvalid, o_rready;
  logic [DATA_W-1:0] i_rdata, o_wdata;
  logic [STRB_W-1:0] o_wstrb;
  logic              o_awvalid, i_awready, o_wlast, o_wvalid, i_wready;
  logic [1:0]        i_bresp;
  logic              i_bvalid, o_bready;

  // unwritten words of the memory model read back as address ^ FILL
  logic [DATA_W-1:0] wmem [logic [ADDR_W-1:0]];
  ar_req_t           rq [$];
  ar_req_t           ar_log [$];
  ar_req_t           ar_seen;
  bit                stall_en;
  bit                ar_fire, r_fire, aw_fire, w_fire, b_fire;
  int                b_count;
  logic [ADDR_W-1:0] aw_log_addr;
  logic [ID_W-1:0]   aw_log_id;
  logic [DATA_W-1:0] w_log_data;
  logic [STRB_W-1:0] w_log_strb;
  logic              w_log_last;
  logic [DATA_W-1:0] iret_q [$];
  logic              iret_last_q [$];
  logic [DATA_W-1:0] dret_q [$];
  logic              dret_last_q [$];

  int errors;
  int tests_run;
  int tests_failed;
  int assert_fails;

  mem_bridge_top #(
    .LINE_BEATS(LINE_BEATS)
  ) u_dut (.*);

  always #2 aclk = ~aclk;

  function automatic logic [DATA_W-1:0] mem_read(input logic [ADDR_W-1:0] addr);
    if (wmem.exists(addr)) begin
      return wmem[addr];
    end
    return addr ^ FILL;
  endfunction

  // AXI slave acting at the falling edge on handshakes from the last rising edge
  initial begin
    int               beat;
    logic             got_aw;
    logic             got_w;
    logic [DATA_W-1:0] word;
    beat      = 0;
    got_aw    = 1'b0;
    got_w     = 1'b0;
    b_count   = 0;
    ar_fire   = 1'b0;
    r_fire    = 1'b0;
    aw_fire   = 1'b0;
    w_fire    = 1'b0;
    b_fire    = 1'b0;
    i_arready = 1'b0;
    i_rvalid  = 1'b0;
    i_rid     = '0;
    i_rdata   = '0;
    i_rlast   = 1'b0;
    i_awready = 1'b0;
    i_wready  = 1'b0;
    i_bvalid  = 1'b0;
    i_bid     = '0;
    i_bresp   = 2'b00;
    forever begin
      @(negedge aclk);
      if (o_iret_valid) begin
        iret_q.push_back(o_iret_data);
        iret_last_q.push_back(o_iret_last);
      end
      if (o_dret_valid) begin
        dret_q.push_back(o_dret_data);
        dret_last_q.push_back(o_dret_last);
      end
      if (ar_fire) begin
        rq.push_back(ar_seen);
      end
      if (r_fire) begin
        if (beat == int'(rq[0].len)) begin
          beat = 0;
          void'(rq.pop_front());
        end else begin
          beat++;
        end
      end
      if (aw_fire) begin
        got_aw = 1'b1;
      end
      if (w_fire) begin
        got_w = 1'b1;
      end
      i_arready = !stall_en || ($urandom % 3 != 0);
      if (!(i_rvalid && !r_fire)) begin
        i_rvalid = (rq.size() > 0) && (!stall_en || ($urandom % 3 != 0));
        if (i_rvalid) begin
          i_rid   = rq[0].id;
          i_rdata = mem_read(rq[0].addr + 4 * beat);
          i_rlast = (beat == int'(rq[0].len));
        end
      end
      i_awready = !stall_en || ($urandom % 3 != 0);
      i_wready  = !stall_en || ($urandom % 3 != 0);
      if (b_fire) begin
        word = mem_read(aw_log_addr);
        for (int b = 0; b < STRB_W; b++) begin
          if (w_log_strb[b]) begin
            word[8*b +: 8] = w_log_data[8*b +: 8];
          end
        end
        wmem[aw_log_addr] = word;
        b_count++;
        got_aw   = 1'b0;
        got_w    = 1'b0;
        i_bvalid = 1'b0;
      end else if (got_aw && got_w && !i_bvalid) begin
        i_bvalid = !stall_en || ($urandom % 3 != 0);
        i_bid    = ID_DATA;
        i_bresp  = 2'b00;
      end
      // the next rising edge sees these values
      #1;
      ar_fire = o_arvalid & i_arready;
      r_fire  = i_rvalid & o_rready;
      aw_fire = o_awvalid & i_awready;
      w_fire  = o_wvalid & i_wready;
      b_fire  = i_bvalid & o_bready;
      if (ar_fire) begin
        ar_seen = {o_arid, o_araddr, o_arlen};
        ar_log.push_back(ar_seen);
      end
      if (aw_fire) begin
        aw_log_addr = o_awaddr;
        aw_log_id   = o_awid;
      end
      if (w_fire) begin
        w_log_data = o_wdata;
        w_log_strb = o_wstrb;
        w_log_last = o_wlast;
      end
    end
  end

  task automatic report_mismatch(input string tname, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("error %s: %s expected %h actual %h", tname, what, exp, act);
    errors++;
  endtask

  task automatic report_failure(input string tname, input string what);
    $display("%s: %s", tname, what);
    errors++;
  endtask

  task automatic end_test(input string tname, input int errs0);
    tests_run++;
    if (errors == errs0) begin
      $display("test %s: passed", tname);
    end else begin
      tests_failed++;
      $display("test %s: failed", tname);
    end
  endtask

  task automatic clear_logs();
    iret_q.delete();
    iret_last_q.delete();
    dret_q.delete();
    dret_last_q.delete();
    ar_log.delete();
  endtask

  task automatic ird_request(input string tname, input logic [ADDR_W-1:0] addr,
                             input logic line);
    int n;
    i_ird_req  = 1'b1;
    i_ird_addr = addr;
    i_ird_line = line;
    n = 0;
    #1;
    while (!o_ird_rdy && n < TIMEOUT) begin
      @(negedge aclk);
      #1;
      n++;
    end
    if (!o_ird_rdy) begin
      report_failure(tname, "instruction read request was never accepted");
    end
    @(negedge aclk);
    i_ird_req = 1'b0;
  endtask

  task automatic drd_request(input string tname, input logic [ADDR_W-1:0] addr,
                             input logic line);
    int n;
    i_drd_req  = 1'b1;
    i_drd_addr = addr;
    i_drd_line = line;
    n = 0;
    #1;
    while (!o_drd_rdy && n < TIMEOUT) begin
      @(negedge aclk);
      #1;
      n++;
    end
    if (!o_drd_rdy) begin
      report_failure(tname, "data read request was never accepted");
    end
    @(negedge aclk);
    i_drd_req = 1'b0;
  endtask

  task automatic store_request(input string tname, input logic [ADDR_W-1:0] addr,
                               input logic [STRB_W-1:0] strb,
                               input logic [DATA_W-1:0] data);
    int n;
    i_dwr_req  = 1'b1;
    i_dwr_addr = addr;
    i_dwr_strb = strb;
    i_dwr_data = data;
    n = 0;
    #1;
    while (!o_dwr_rdy && n < TIMEOUT) begin
      @(negedge aclk);
      #1;
      n++;
    end
    if (!o_dwr_rdy) begin
      report_failure(tname, "store request was never accepted");
    end
    @(negedge aclk);
    i_dwr_req = 1'b0;
  endtask

  function automatic bit last_seen(input bit inst);
    if (inst) begin
      return iret_last_q.size() > 0 && iret_last_q[$] === 1'b1;
    end
    return dret_last_q.size() > 0 && dret_last_q[$] === 1'b1;
  endfunction

  task automatic wait_last(input string tname, input bit inst);
    int n;
    n = 0;
    while (!last_seen(inst) && n < TIMEOUT) begin
      @(posedge aclk);
      n++;
    end
    if (!last_seen(inst)) begin
      report_failure(tname, inst ? "no last beat on the instruction return port"
                                 : "no last beat on the data return port");
    end
  endtask

  // beat i carries the word at addr + 4*i
  task automatic check_beats(input string tname, input bit inst,
                             input logic [ADDR_W-1:0] addr, input int beats);
    logic [DATA_W-1:0] data_q [$];
    logic              last_q [$];
    logic [DATA_W-1:0] exp;
    if (inst) begin
      data_q = iret_q;
      last_q = iret_last_q;
    end else begin
      data_q = dret_q;
      last_q = dret_last_q;
    end
    if (data_q.size() != beats) begin
      report_mismatch(tname, "beat count", beats, data_q.size());
    end
    for (int i = 0; i < data_q.size() && i < beats; i++) begin
      exp = (addr + 4 * i) ^ FILL;
      if (data_q[i] !== exp) begin
        report_mismatch(tname, "return data", exp, data_q[i]);
      end
      if (last_q[i] !== (i == beats - 1)) begin
        report_mismatch(tname, "return last", (i == beats - 1), last_q[i]);
      end
    end
  endtask

  task automatic reset_state();
    int errs0;
    errs0 = errors;
    #1;
    if (o_arvalid !== 1'b0) report_mismatch("reset_state", "arvalid", 0, o_arvalid);
    if (o_awvalid !== 1'b0) report_mismatch("reset_state", "awvalid", 0, o_awvalid);
    if (o_wvalid !== 1'b0) report_mismatch("reset_state", "wvalid", 0, o_wvalid);
    if (o_iret_valid !== 1'b0) report_mismatch("reset_state", "iret_valid", 0, o_iret_valid);
    if (o_dret_valid !== 1'b0) report_mismatch("reset_state", "dret_valid", 0, o_dret_valid);
    if (o_ird_rdy !== 1'b1) report_mismatch("reset_state", "ird_rdy", 1, o_ird_rdy);
    if (o_drd_rdy !== 1'b1) report_mismatch("reset_state", "drd_rdy", 1, o_drd_rdy);
    if (o_dwr_rdy !== 1'b1) report_mismatch("reset_state", "dwr_rdy", 1, o_dwr_rdy);
    if (o_rready !== 1'b1) report_mismatch("reset_state", "rready", 1, o_rready);
    @(negedge aclk);
    end_test("reset_state", errs0);
  endtask

  task automatic inst_line_read();
    string tname;
    int    errs0;
    tname = "inst_line_read";
    errs0 = errors;
    clear_logs();
    ird_request(tname, 32'h0000_0040, 1'b1);
    wait_last(tname, 1'b1);
    if (ar_log.size() != 1) begin
      report_mismatch(tname, "address handshakes", 1, ar_log.size());
    end else begin
      if (ar_log[0].id !== ID_INST) report_mismatch(tname, "arid", ID_INST, ar_log[0].id);
      if (ar_log[0].len !== 8'd3) report_mismatch(tname, "arlen", 3, ar_log[0].len);
      if (ar_log[0].addr !== 32'h40) report_mismatch(tname, "araddr", 32'h40, ar_log[0].addr);
    end
    check_beats(tname, 1'b1, 32'h0000_0040, LINE_BEATS);
    @(negedge aclk);
    end_test(tname, errs0);
  endtask

  task automatic data_word_read();
    string tname;
    int    errs0;
    tname = "data_word_read";
    errs0 = errors;
    clear_logs();
    drd_request(tname, 32'h0000_0084, 1'b0);
    wait_last(tname, 1'b0);
    if (ar_log.size() != 1) begin
      report_mismatch(tname, "address handshakes", 1, ar_log.size());
    end else begin
      if (ar_log[0].id !== ID_DATA) report_mismatch(tname, "arid", ID_DATA, ar_log[0].id);
      if (ar_log[0].len !== 8'd0) report_mismatch(tname, "arlen", 0, ar_log[0].len);
    end
    check_beats(tname, 1'b0, 32'h0000_0084, 1);
    @(negedge aclk);
    end_test(tname, errs0);
  endtask

  task automatic store_then_load();
    string             tname;
    int                errs0;
    int                n;
    int                b0;
    bit                dwr_early;
    logic [DATA_W-1:0] exp;
    tname     = "store_then_load";
    errs0     = errors;
    dwr_early = 1'b0;
    clear_logs();
    b0 = b_count;
    store_request(tname, 32'h0000_0100, 4'b0110, 32'hdead_beef);
    // load is held back while the store is pending
    i_drd_req  = 1'b1;
    i_drd_addr = 32'h0000_0100;
    i_drd_line = 1'b0;
    n = 0;
    #1;
    while (b_count == b0 && !o_drd_rdy && n < TIMEOUT) begin
      if (o_dwr_rdy) dwr_early = 1'b1;
      @(negedge aclk);
      #1;
      n++;
    end
    if (dwr_early) begin
      report_failure(tname, "o_dwr_rdy went high before the write response");
    end
    if (b_count == b0) begin
      if (o_drd_rdy) begin
        report_failure(tname, "o_drd_rdy went high before the write response");
      end else begin
        report_failure(tname, "timed out waiting for the write response");
      end
    end else if (!o_drd_rdy) begin
      report_failure(tname, "o_drd_rdy stayed low after the write response");
    end
    @(negedge aclk);
    i_drd_req = 1'b0;
    if (aw_log_addr !== 32'h100) report_mismatch(tname, "awaddr", 32'h100, aw_log_addr);
    if (aw_log_id !== ID_DATA) report_mismatch(tname, "awid", ID_DATA, aw_log_id);
    if (w_log_strb !== 4'b0110) report_mismatch(tname, "wstrb", 4'b0110, w_log_strb);
    if (w_log_data !== 32'hdead_beef) report_mismatch(tname, "wdata", 32'hdead_beef, w_log_data);
    if (w_log_last !== 1'b1) report_mismatch(tname, "wlast", 1, w_log_last);
    wait_last(tname, 1'b0);
    // bytes 1 and 2 come from the store
    exp = 32'h0000_0100 ^ FILL;
    exp[23:8] = 16'hadbe;
    if (dret_q.size() != 1) begin
      report_mismatch(tname, "beat count", 1, dret_q.size());
    end else if (dret_q[0] !== exp) begin
      report_mismatch(tname, "load data", exp, dret_q[0]);
    end
    @(negedge aclk);
    end_test(tname, errs0);
  endtask

  task automatic concurrent_reads();
    string             tname;
    int                errs0;
    logic [ADDR_W-1:0] iaddr;
    logic [ADDR_W-1:0] daddr;
    logic              dline;
    tname    = "concurrent_reads";
    errs0    = errors;
    stall_en = 1'b1;
    for (int k = 0; k < 4; k++) begin
      clear_logs();
      iaddr = 32'h0002_0000 | ($urandom & 32'h0000_3ff0);
      daddr = 32'h0003_0000 | ($urandom & 32'h0000_3ff0);
      dline = $urandom % 2;
      fork
        drd_request(tname, daddr, dline);
        ird_request(tname, iaddr, 1'b1);
      join
      wait_last(tname, 1'b1);
      wait_last(tname, 1'b0);
      if (ar_log.size() != 2) begin
        report_mismatch(tname, "address handshakes", 2, ar_log.size());
      end else begin
        if (ar_log[0].id !== ID_DATA) report_mismatch(tname, "first arid", ID_DATA, ar_log[0].id);
        if (ar_log[1].id !== ID_INST) report_mismatch(tname, "second arid", ID_INST, ar_log[1].id);
        if (ar_log[0].addr !== daddr) report_mismatch(tname, "data araddr", daddr, ar_log[0].addr);
      end
      check_beats(tname, 1'b1, iaddr, LINE_BEATS);
      check_beats(tname, 1'b0, daddr, dline ? LINE_BEATS : 1);
      @(negedge aclk);
    end
    stall_en = 1'b0;
    end_test(tname, errs0);
  endtask

  initial begin
    void'($urandom(32'h8b94_b227));
    aclk         = 1'b0;
    i_rst_n      = 1'b0;
    i_ird_req    = 1'b0;
    i_ird_addr   = '0;
    i_ird_line   = 1'b0;
    i_drd_req    = 1'b0;
    i_drd_addr   = '0;
    i_drd_line   = 1'b0;
    i_dwr_req    = 1'b0;
    i_dwr_addr   = '0;
    i_dwr_strb   = '0;
    i_dwr_data   = '0;
    stall_en     = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    i_rst_n = 1'b1;
    reset_state();
    inst_line_read();
    data_word_read();
    store_then_load();
    concurrent_reads();
    // protocol assertion failures count as errors too
    assert_fails = u_dut.u_asserts.fail_count;
    errors       = errors + assert_fails;
    $display("%0d tests run, %0d failed, %0d assertion failures, %0d errors",
             tests_run, tests_failed, assert_fails, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: common/bridge_pkg.sv
package bridge_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;
  localparam int ID_W   = 4;
  localparam int LEN_W  = 8;

  // fixed AXI ids per requester
  localparam logic [ID_W-1:0] ID_INST = 4'd0;
  localparam logic [ID_W-1:0] ID_DATA = 4'd1;

  // read address channel payload, 44 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } ar_req_t;

  // single-word store, 68 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] data;
  } wr_req_t;

endpackage

// File: design/mem_bridge_top.sv
`timescale 1ns/1ns

module mem_bridge_top import bridge_pkg::*; #(
  parameter int LINE_BEATS = 4
) (
  input  logic              aclk,
  input  logic              i_rst_n,
  // instruction read requests
  input  logic              i_ird_req,
  input  logic [ADDR_W-1:0] i_ird_addr,
  input  logic              i_ird_line,
  output logic              o_ird_rdy,
  // data read requests
  input  logic              i_drd_req,
  input  logic [ADDR_W-1:0] i_drd_addr,
  input  logic              i_drd_line,
  output logic              o_drd_rdy,
  // stores
  input  logic              i_dwr_req,
  input  logic [ADDR_W-1:0] i_dwr_addr,
  input  logic [STRB_W-1:0] i_dwr_strb,
  input  logic [DATA_W-1:0] i_dwr_data,
  output logic              o_dwr_rdy,
  // return ports
  output logic              o_iret_valid,
  output logic              o_iret_last,
  output logic [DATA_W-1:0] o_iret_data,
  output logic              o_dret_valid,
  output logic              o_dret_last,
  output logic [DATA_W-1:0] o_dret_data,
  // axi read address
  output logic [ID_W-1:0]   o_arid,
  output logic [ADDR_W-1:0] o_araddr,
  output logic [LEN_W-1:0]  o_arlen,
  output logic              o_arvalid,
  input  logic              i_arready,
  // axi read data
  input  logic [ID_W-1:0]   i_rid,
  input  logic [DATA_W-1:0] i_rdata,
  input  logic              i_rlast,
  input  logic              i_rvalid,
  output logic              o_rready,
  // axi write address
  output logic [ID_W-1:0]   o_awid,
  output logic [ADDR_W-1:0] o_awaddr,
  output logic              o_awvalid,
  input  logic              i_awready,
  // axi write data
  output logic [DATA_W-1:0] o_wdata,
  output logic [STRB_W-1:0] o_wstrb,
  output logic              o_wlast,
  output logic              o_wvalid,
  input  logic              i_wready,
  // axi write response
  input  logic [ID_W-1:0]   i_bid,
  input  logic [1:0]        i_bresp,
  input  logic              i_bvalid,
  output logic              o_bready
);

  ar_req_t arb_ar_data;
  ar_req_t ar_q;
  logic    arb_ar_valid;
  logic    ar_slot_ready;
  logic    inst_done;
  logic    data_done;
  logic    wbuf_empty;

  read_arbiter #(
    .LINE_BEATS(LINE_BEATS)
  ) u_read_arbiter (
    .aclk        (aclk),
    .i_rst_n     (i_rst_n),
    .i_ird_req   (i_ird_req),
    .i_ird_addr  (i_ird_addr),
    .i_ird_line  (i_ird_line),
    .i_drd_req   (i_drd_req),
    .i_drd_addr  (i_drd_addr),
    .i_drd_line  (i_drd_line),
    .i_wbuf_empty(wbuf_empty),
    .i_ar_ready  (ar_slot_ready),
    .i_inst_done (inst_done),
    .i_data_done (data_done),
    .o_ird_rdy   (o_ird_rdy),
    .o_drd_rdy   (o_drd_rdy),
    .o_ar_valid  (arb_ar_valid),
    .o_ar_data   (arb_ar_data)
  );

  pipe_reg #(
    .payload_t(ar_req_t)
  ) u_ar_reg (
    .aclk   (aclk),
    .i_rst_n(i_rst_n),
    .i_valid(arb_ar_valid),
    .i_data (arb_ar_data),
    .o_ready(ar_slot_ready),
    .o_valid(o_arvalid),
    .o_data (ar_q),
    .i_ready(i_arready)
  );

  assign o_arid   = ar_q.id;
  assign o_araddr = ar_q.addr;
  assign o_arlen  = ar_q.len;

  read_return u_read_return (
    .aclk        (aclk),
    .i_rst_n     (i_rst_n),
    .i_rvalid    (i_rvalid),
    .i_rid       (i_rid),
    .i_rdata     (i_rdata),
    .i_rlast     (i_rlast),
    .o_rready    (o_rready),
    .o_iret_valid(o_iret_valid),
    .o_iret_last (o_iret_last),
    .o_iret_data (o_iret_data),
    .o_dret_valid(o_dret_valid),
    .o_dret_last (o_dret_last),
    .o_dret_data (o_dret_data),
    .o_inst_done (inst_done),
    .o_data_done (data_done)
  );

  write_buffer u_write_buffer (
    .aclk      (aclk),
    .i_rst_n   (i_rst_n),
    .i_dwr_req (i_dwr_req),
    .i_dwr_addr(i_dwr_addr),
    .i_dwr_strb(i_dwr_strb),
    .i_dwr_data(i_dwr_data),
    .i_awready (i_awready),
    .i_wready  (i_wready),
    .i_bvalid  (i_bvalid),
    .o_dwr_rdy (o_dwr_rdy),
    .o_awvalid (o_awvalid),
    .o_awaddr  (o_awaddr),
    .o_wvalid  (o_wvalid),
    .o_wdata   (o_wdata),
    .o_wstrb   (o_wstrb),
    .o_bready  (o_bready),
    .o_empty   (wbuf_empty)
  );

  // single-beat stores from the data side only
  assign o_awid  = ID_DATA;
  assign o_wlast = 1'b1;

endmodule

// File: design/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     aclk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_ready,
  output logic     o_valid,
  output payload_t o_data,
  input  logic     i_ready
);

  logic     out_valid;
  logic     skid_valid;
  payload_t out_data;
  payload_t skid_data;
  logic     accept;
  logic     advance;

  // ready only depends on the skid slot, so it comes straight from a flop
  assign o_ready = ~skid_valid;
  assign accept  = i_valid & ~skid_valid;
  assign advance = ~out_valid | i_ready;

  assign o_valid = out_valid;
  assign o_data  = out_data;

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (advance) begin
      out_valid  <= skid_valid | accept;
      skid_valid <= 1'b0;
    end else if (accept) begin
      // output stalled, park the new item
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (advance) begin
      out_data <= skid_valid ? skid_data : i_data;
    end
    if (!advance && accept) begin
      skid_data <= i_data;
    end
  end

endmodule

// File: read/read_arbiter.sv
`timescale 1ns/1ns

module read_arbiter import bridge_pkg::*; #(
  parameter int LINE_BEATS = 4
) (
  input  logic              aclk,
  input  logic              i_rst_n,
  input  logic              i_ird_req,
  input  logic [ADDR_W-1:0] i_ird_addr,
  input  logic              i_ird_line,
  input  logic              i_drd_req,
  input  logic [ADDR_W-1:0] i_drd_addr,
  input  logic              i_drd_line,
  input  logic              i_wbuf_empty,
  input  logic              i_ar_ready,
  input  logic              i_inst_done,
  input  logic              i_data_done,
  output logic              o_ird_rdy,
  output logic              o_drd_rdy,
  output logic              o_ar_valid,
  output ar_req_t           o_ar_data
);

  localparam logic [LEN_W-1:0] LINE_LEN = LEN_W'(LINE_BEATS - 1);

  logic inst_busy;
  logic data_busy;
  logic ird_fire;
  logic drd_fire;

  // loads wait behind a pending store
  assign o_drd_rdy = ~data_busy & i_wbuf_empty & i_ar_ready;
  assign drd_fire  = i_drd_req & o_drd_rdy;

  // data side wins a tie
  assign o_ird_rdy = ~inst_busy & i_ar_ready & ~drd_fire;
  assign ird_fire  = i_ird_req & o_ird_rdy;

  assign o_ar_valid = drd_fire | ird_fire;

  always_comb begin
    if (drd_fire) begin
      o_ar_data.id   = ID_DATA;
      o_ar_data.addr = i_drd_addr;
      o_ar_data.len  = i_drd_line ? LINE_LEN : '0;
    end else begin
      o_ar_data.id   = ID_INST;
      o_ar_data.addr = i_ird_addr;
      o_ar_data.len  = i_ird_line ? LINE_LEN : '0;
    end
  end

  // one read in flight per side
  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      inst_busy <= 1'b0;
      data_busy <= 1'b0;
    end else begin
      if (ird_fire) begin
        inst_busy <= 1'b1;
      end else if (i_inst_done) begin
        inst_busy <= 1'b0;
      end
      if (drd_fire) begin
        data_busy <= 1'b1;
      end else if (i_data_done) begin
        data_busy <= 1'b0;
      end
    end
  end

endmodule

// File: read/read_return.sv
`timescale 1ns/1ns

module read_return import bridge_pkg::*; (
  input  logic              aclk,
  input  logic              i_rst_n,
  input  logic              i_rvalid,
  input  logic [ID_W-1:0]   i_rid,
  input  logic [DATA_W-1:0] i_rdata,
  input  logic              i_rlast,
  output logic              o_rready,
  output logic              o_iret_valid,
  output logic              o_iret_last,
  output logic [DATA_W-1:0] o_iret_data,
  output logic              o_dret_valid,
  output logic              o_dret_last,
  output logic [DATA_W-1:0] o_dret_data,
  output logic              o_inst_done,
  output logic              o_data_done
);

  logic inst_beat;
  logic data_beat;

  // return ports have no back-pressure
  assign o_rready = 1'b1;

  assign inst_beat = i_rvalid & (i_rid == ID_INST);
  assign data_beat = i_rvalid & (i_rid == ID_DATA);

  assign o_inst_done = inst_beat & i_rlast;
  assign o_data_done = data_beat & i_rlast;

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      o_iret_valid <= 1'b0;
      o_dret_valid <= 1'b0;
    end else begin
      o_iret_valid <= inst_beat;
      o_dret_valid <= data_beat;
    end
  end

  always_ff @(posedge aclk) begin
    if (inst_beat) begin
      o_iret_data <= i_rdata;
      o_iret_last <= i_rlast;
    end
    if (data_beat) begin
      o_dret_data <= i_rdata;
      o_dret_last <= i_rlast;
    end
  end

endmodule

// File: sim.f
common/bridge_pkg.sv
design/pipe_reg.sv
read/read_arbiter.sv
read/read_return.sv
write/write_buffer.sv
design/mem_bridge_top.sv
bench/mem_bridge_asserts.sv
bench/tb_mem_bridge.sv

// File: write/write_buffer.sv
`timescale 1ns/1ns

module write_buffer import bridge_pkg::*; (
  input  logic              aclk,
  input  logic              i_rst_n,
  input  logic              i_dwr_req,
  input  logic [ADDR_W-1:0] i_dwr_addr,
  input  logic [STRB_W-1:0] i_dwr_strb,
  input  logic [DATA_W-1:0] i_dwr_data,
  input  logic              i_awready,
  input  logic              i_wready,
  input  logic              i_bvalid,
  output logic              o_dwr_rdy,
  output logic              o_awvalid,
  output logic [ADDR_W-1:0] o_awaddr,
  output logic              o_wvalid,
  output logic [DATA_W-1:0] o_wdata,
  output logic [STRB_W-1:0] o_wstrb,
  output logic              o_bready,
  output logic              o_empty
);

  wr_req_t store_q;
  logic    full;
  logic    aw_pend;
  logic    w_pend;
  logic    take;
  logic    resp_done;

  assign o_dwr_rdy = ~full;
  assign o_empty   = ~full;
  assign take      = i_dwr_req & ~full;

  // both beats sent, now waiting on B
  assign o_bready  = full & ~aw_pend & ~w_pend;
  assign resp_done = o_bready & i_bvalid;

  assign o_awvalid = aw_pend;
  assign o_wvalid  = w_pend;
  assign o_awaddr  = store_q.addr;
  assign o_wdata   = store_q.data;
  assign o_wstrb   = store_q.strb;

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      full    <= 1'b0;
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
    end else if (take) begin
      full    <= 1'b1;
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end else begin
      // aw and w may complete in either order
      if (aw_pend && i_awready) begin
        aw_pend <= 1'b0;
      end
      if (w_pend && i_wready) begin
        w_pend <= 1'b0;
      end
      if (resp_done) begin
        full <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      store_q.addr <= i_dwr_addr;
      store_q.strb <= i_dwr_strb;
      store_q.data <= i_dwr_data;
    end
  end

endmodule
